//--- logic/lead_zero_count.sv
`timescale 1ns/1ps

module lead_zero_count #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0]           bits,
  output logic [$clog2(WIDTH+1)-1:0] count
);

  if (WIDTH == 1) begin : g_leaf
    assign count = ~bits[0];
  end else begin : g_split
    // Left half is a power of two, right half takes the rest
    localparam int L  = 2 ** ($clog2(WIDTH) - 1);
    localparam int R  = WIDTH - L;
    localparam int LW = $clog2(L + 1);
    localparam int RW = $clog2(R + 1);
    localparam int CW = $clog2(WIDTH + 1);

    logic [LW-1:0] left_count;
    logic [RW-1:0] right_count;
    logic          left_zero;
    logic          right_zero;

    lead_zero_count #(.WIDTH(L)) u_left (
      .bits  (bits[WIDTH-1 -: L]),
      .count (left_count)
    );

    lead_zero_count #(.WIDTH(R)) u_right (
      .bits  (bits[R-1:0]),
      .count (right_count)
    );

    // Count reaches L only when the whole left half is zero
    assign left_zero  = left_count[LW-1];
    assign right_zero = (right_count == RW'(R));

    // L is a power of two and the right count stays below it, so OR adds
    always_comb begin
      if (left_zero && right_zero) begin
        count = CW'(WIDTH);
      end else if (!left_zero) begin
        count = CW'(left_count);
      end else begin
        count = CW'(L) | CW'(right_count);
      end
    end
  end

endmodule

//--- logic/slide_down_path.sv
`timescale 1ns/1ps

module slide_down_path (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  input  vslide_beat_pkg::slide_req_t req,
  output vslide_beat_pkg::path_res_t  down_res
);

  import vslide_types_pkg::*;

  vec_data_t  vec_s0;
  vec_data_t  scalar_s0;
  sew_code_t  sew_s0;
  logic       last_s0;
  byte_en_t   avl_be_s0;
  logic [6:0] elem_w_s0;
  lzc_t       lzc_s0;
  vec_data_t  kept_s0;
  vec_data_t  carry_s0;
  vec_data_t  scalar_top_s0;
  vec_data_t  placed_s0;

  vec_data_t  kept_s1;
  vec_data_t  placed_s1;
  logic       last_s1;

  always_ff @(posedge clk) begin
    if (rst) begin
      vec_s0    <= '0;
      scalar_s0 <= '0;
      sew_s0    <= '0;
      last_s0   <= 1'b0;
      avl_be_s0 <= '0;
    end else begin
      vec_s0    <= in_valid ? req.vec : '0;
      scalar_s0 <= in_valid ? req.scalar : '0;
      sew_s0    <= in_valid ? req.sew : '0;
      last_s0   <= in_valid & req.last;
      avl_be_s0 <= in_valid ? req.avl_be : '0;
    end
  end

  // Unused bytes above the active part of the last beat
  lead_zero_count #(.WIDTH($bits(byte_en_t))) u_lzc (
    .bits  (avl_be_s0),
    .count (lzc_s0)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stage 0 shift
  ////////////////////////////////////////////////////////////////////////////

  // Lower half comes out already top aligned for the beat ahead
  always_comb begin
    elem_w_s0           = 7'd8 << sew_s0;
    {kept_s0, carry_s0} = {vec_s0, {$bits(vec_data_t){1'b0}}} >> elem_w_s0;
    scalar_top_s0       = scalar_s0 << (7'($bits(vec_data_t)) - elem_w_s0);
    // One byte down per unused byte lane
    placed_s0           = scalar_top_s0 >> {lzc_s0, 3'b000};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stages 1 and 2
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      kept_s1   <= '0;
      placed_s1 <= '0;
      last_s1   <= 1'b0;
      down_res  <= '0;
    end else begin
      kept_s1   <= kept_s0;
      placed_s1 <= placed_s0;
      last_s1   <= last_s0;
      // Following beat sits in stage 0 right now
      down_res.vec <= kept_s1 | (last_s1 ? placed_s1 : carry_s0);
    end
  end

endmodule

//--- logic/slide_merge.sv
`timescale 1ns/1ps

`include "vslide_consts.svh"

module slide_merge (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  vslide_beat_pkg::slide_req_t  req,
  input  vslide_beat_pkg::path_res_t   up_res,
  input  vslide_beat_pkg::path_res_t   down_res,
  output logic                         out_valid,
  output vslide_beat_pkg::slide_resp_t resp
);

  import vslide_types_pkg::*;

  localparam int N_STAGES  = `VS_LATENCY;
  // Stage where the path results are ready
  localparam int SEL_STAGE = 2;

  logic      valid_q [N_STAGES];
  logic      down_q  [SEL_STAGE+1];
  vaddr_t    addr_q  [N_STAGES];
  byte_en_t  be_q    [N_STAGES];
  elem_off_t off_q   [N_STAGES];
  vec_data_t res_q   [SEL_STAGE+1:N_STAGES-1];
  vec_data_t sel_vec;

  assign sel_vec = down_q[SEL_STAGE] ? down_res.vec : up_res.vec;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < N_STAGES; s++) begin
        valid_q[s] <= 1'b0;
        addr_q[s]  <= '0;
        be_q[s]    <= '0;
        off_q[s]   <= '0;
      end
      for (int s = 0; s <= SEL_STAGE; s++) begin
        down_q[s] <= 1'b0;
      end
      for (int s = SEL_STAGE + 1; s < N_STAGES; s++) begin
        res_q[s] <= '0;
      end
    end else begin
      valid_q[0] <= in_valid;
      down_q[0]  <= in_valid & req.down;
      addr_q[0]  <= in_valid ? req.addr : '0;
      be_q[0]    <= in_valid ? req.be : '0;
      // Slide-down writes back from element zero
      off_q[0]   <= (in_valid && !req.down) ? req.off : '0;
      for (int s = 1; s < N_STAGES; s++) begin
        valid_q[s] <= valid_q[s-1];
        addr_q[s]  <= addr_q[s-1];
        be_q[s]    <= be_q[s-1];
        off_q[s]   <= off_q[s-1];
      end
      for (int s = 1; s <= SEL_STAGE; s++) begin
        down_q[s] <= down_q[s-1];
      end
      res_q[SEL_STAGE+1] <= sel_vec;
      for (int s = SEL_STAGE + 2; s < N_STAGES; s++) begin
        res_q[s] <= res_q[s-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////////////////////

  assign out_valid = valid_q[N_STAGES-1];
  assign resp.vec  = valid_q[N_STAGES-1] ? res_q[N_STAGES-1] : '0;
  assign resp.be   = be_q[N_STAGES-1];
  assign resp.addr = addr_q[N_STAGES-1];
  assign resp.off  = off_q[N_STAGES-1];

endmodule

//--- logic/slide_up_path.sv
`timescale 1ns/1ps

module slide_up_path (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  input  vslide_beat_pkg::slide_req_t req,
  output vslide_beat_pkg::path_res_t  up_res
);

  import vslide_types_pkg::*;

  vec_data_t  vec_s0;
  vec_data_t  scalar_s0;
  sew_code_t  sew_s0;
  logic       start_s0;
  logic [6:0] elem_w_s0;
  vec_data_t  kept_s0;
  vec_data_t  carry_s0;
  vec_data_t  fill_s0;

  vec_data_t  kept_s1;
  vec_data_t  carry_s1;
  vec_data_t  fill_s1;
  logic       start_s1;
  vec_data_t  carry_s2;

  // Stage 0 capture, empty slots hold zero
  always_ff @(posedge clk) begin
    if (rst) begin
      vec_s0    <= '0;
      scalar_s0 <= '0;
      sew_s0    <= '0;
      start_s0  <= 1'b0;
    end else begin
      vec_s0    <= in_valid ? req.vec : '0;
      scalar_s0 <= in_valid ? req.scalar : '0;
      sew_s0    <= in_valid ? req.sew : '0;
      start_s0  <= in_valid & req.start;
    end
  end

  // Upper half of the wide shift is the element leaving the top
  always_comb begin
    elem_w_s0           = 7'd8 << sew_s0;
    {carry_s0, kept_s0} = {{$bits(vec_data_t){1'b0}}, vec_s0} << elem_w_s0;
    fill_s0             = scalar_s0 & ~(vec_data_t'('1) << elem_w_s0);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      kept_s1  <= '0;
      carry_s1 <= '0;
      fill_s1  <= '0;
      start_s1 <= 1'b0;
      carry_s2 <= '0;
      up_res   <= '0;
    end else begin
      kept_s1  <= kept_s0;
      carry_s1 <= carry_s0;
      fill_s1  <= fill_s0;
      start_s1 <= start_s0;
      // Holds the outgoing element of the beat one ahead
      carry_s2 <= carry_s1;
      up_res.vec <= kept_s1 | (start_s1 ? fill_s1 : carry_s2);
    end
  end

endmodule

//--- logic/vslide_beat_pkg.sv
package vslide_beat_pkg;

  import vslide_types_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vec_data_t vec;     // Beat data
    vec_data_t scalar;  // Insert value, low element used
    sew_code_t sew;
    logic      down;    // 1 for slide-down, 0 for slide-up
    logic      start;   // First beat of the register
    logic      last;    // Final beat of the register
    vaddr_t    addr;
    byte_en_t  be;
    byte_en_t  avl_be;  // Active bytes, only looked at on the last beat
    elem_off_t off;
  } slide_req_t;

  // Stage 2 output of one direction
  typedef struct packed {
    vec_data_t vec;
  } path_res_t;

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vec_data_t vec;
    byte_en_t  be;
    vaddr_t    addr;
    elem_off_t off;
  } slide_resp_t;

endpackage

//--- logic/vslide_consts.svh
`ifndef VSLIDE_CONSTS_SVH
`define VSLIDE_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Beat geometry
////////////////////////////////////////////////////////////////////////////

// One beat of vector data
`define VS_DATA_W 64

// Byte lanes per beat
`define VS_BE_W 8

// Request address
`define VS_ADDR_W 32

// Element offset passed to the writeback side
`define VS_OFF_W 12

////////////////////////////////////////////////////////////////////////////
// Pipeline
////////////////////////////////////////////////////////////////////////////

// Input strobe to output strobe, in cycles
`define VS_LATENCY 6

`endif

//--- logic/vslide_types_pkg.sv
`include "vslide_consts.svh"

package vslide_types_pkg;

  // One beat of element data
  typedef logic [`VS_DATA_W-1:0] vec_data_t;

  // Byte-lane mask, bit i covers byte i of the beat
  typedef logic [`VS_BE_W-1:0] byte_en_t;

  // Beat address
  typedef logic [`VS_ADDR_W-1:0] vaddr_t;

  // Element offset
  typedef logic [`VS_OFF_W-1:0] elem_off_t;

  // Element width code
  //   0 -> 8 bit, 1 -> 16 bit, 2 -> 32 bit, 3 -> 64 bit
  // Element width in bits is 8 << code
  typedef logic [1:0] sew_code_t;

  // Leading zeros of a byte mask, 0 up to VS_BE_W
  typedef logic [$clog2(`VS_BE_W + 1)-1:0] lzc_t;

endpackage

//--- logic/vslide_unit.sv
`timescale 1ns/1ps

module vslide_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  vslide_beat_pkg::slide_req_t  req,
  output logic                         out_valid,
  output vslide_beat_pkg::slide_resp_t resp
);

  import vslide_beat_pkg::*;

  path_res_t up_res;
  path_res_t down_res;

  // Both directions run on every beat, merge picks one
  slide_up_path u_up (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .req      (req),
    .up_res   (up_res)
  );

  slide_down_path u_down (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .req      (req),
    .down_res (down_res)
  );

  slide_merge u_merge (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .up_res    (up_res),
    .down_res  (down_res),
    .out_valid (out_valid),
    .resp      (resp)
  );

endmodule

//--- run.sh
#!/bin/sh
# Compile the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module vslide_tb \
  --Mdir "$BUILD_DIR" \
  -f tb.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$BUILD_DIR/Vvslide_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

//--- tb.f
+incdir+logic
logic/vslide_types_pkg.sv
logic/vslide_beat_pkg.sv
logic/lead_zero_count.sv
logic/slide_up_path.sv
logic/slide_down_path.sv
logic/slide_merge.sv
logic/vslide_unit.sv
verif/vslide_asserts.sv
verif/vslide_tb.sv

//--- verif/vslide_asserts.sv
`timescale 1ns/1ps

`include "vslide_consts.svh"

module vslide_asserts (
  input logic                        clk,
  input logic                        rst,
  input logic                        in_valid,
  input vslide_beat_pkg::slide_req_t req,
  input logic                        out_valid
);

  int lat_fails   = 0;
  int burst_fails = 0;
  int flag_fails  = 0;
  int fail_count;

  assign fail_count = lat_fails + burst_fails + flag_fails;

  // Output strobe mirrors the input strobe
  out_latency: assert property (@(posedge clk) disable iff (rst)
      out_valid == $past(in_valid, `VS_LATENCY))
    else begin
      $error("out_valid does not follow in_valid by the pipeline latency");
      lat_fails++;
    end

  // Beats of one register come back to back
  burst_cont: assert property (@(posedge clk) disable iff (rst)
      (in_valid && !req.last) |=> in_valid)
    else begin
      $error("gap inside a multi-beat operation");
      burst_fails++;
    end

  flags_valid: assert property (@(posedge clk) disable iff (rst)
      (req.start || req.last) |-> in_valid)
    else begin
      $error("start or last flag set without in_valid");
      flag_fails++;
    end

endmodule

bind slide_merge vslide_asserts u_asserts (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .req       (req),
  .out_valid (out_valid)
);

//--- verif/vslide_tb.sv
`timescale 1ns/1ps

`include "vslide_consts.svh"

module vslide_tb;

  import vslide_types_pkg::*;
  import vslide_beat_pkg::*;

  localparam int N_OPS      = 200;
  // 200 operations of up to 4 beats and 2 idle cycles, plus reset and drain
  localparam int MAX_CYCLES = 2000;
  localparam int LATENCY    = `VS_LATENCY;

  logic        clk = 1'b0;
  logic        rst;
  logic        in_valid;
  slide_req_t  req;
  logic        out_valid;
  slide_resp_t resp;

  integer seed   = 17255;
  int     cycle  = 0;
  int     errors = 0;
  int     checks = 0;

  // Expected beats in output order
  slide_resp_t exp_q  [$];
  int          cyc_q  [$];
  string       name_q [$];

  vslide_unit dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .resp      (resp)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic vec_data_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic vec_data_t elem_mask(input int ew);
    if (ew == 64) begin
      return '1;
    end
    return (64'd1 << ew) - 64'd1;
  endfunction

  // Element j of the whole register, counted from beat 0
  function automatic vec_data_t elem_at(input vec_data_t beats [4], input int j, input int ew);
    int ne;
    ne = 64 / ew;
    return (beats[j / ne] >> ((j % ne) * ew)) & elem_mask(ew);
  endfunction

  function automatic vec_data_t ref_slide(input vec_data_t beats [4], input int n, input int b,
                                          input sew_code_t sew, input logic down,
                                          input vec_data_t scalar, input byte_en_t avl);
    int        ew;
    int        ne;
    int        total;
    int        top_act;
    int        j;
    vec_data_t e;
    vec_data_t res;
    ew      = 8 << sew;
    ne      = 64 / ew;
    total   = n * ne;
    // Highest active element, it sits in the last beat
    top_act = (n - 1) * ne + $countones(avl) / (ew / 8) - 1;
    res     = '0;
    for (int i = 0; i < ne; i++) begin
      j = b * ne + i;
      if (!down) begin
        e = (j == 0) ? (scalar & elem_mask(ew)) : elem_at(beats, j - 1, ew);
      end else if (j == top_act) begin
        e = scalar & elem_mask(ew);
      end else if (j + 1 < total) begin
        e = elem_at(beats, j + 1, ew);
      end else begin
        e = '0;
      end
      res = res | (e << (i * ew));
    end
    return res;
  endfunction

  task automatic send_beat(input slide_req_t r, input slide_resp_t e, input string name);
    @(posedge clk);
    #2;
    in_valid = 1'b1;
    req      = r;
    exp_q.push_back(e);
    cyc_q.push_back(cycle + LATENCY);
    name_q.push_back(name);
  endtask

  task automatic send_idle();
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    req      = '0;
    req.vec  = rand64();
  endtask

  task automatic check_field(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("error %s %s expected %h actual %h", test, field, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    vec_data_t   beats [4];
    slide_req_t  r;
    slide_resp_t e;
    vec_data_t   scalar;
    sew_code_t   sew;
    logic        down;
    byte_en_t    avl;
    int          n;
    int          ebytes;
    int          act;
    string       name;
    int          total;

    rst      = 1'b1;
    in_valid = 1'b0;
    req      = '0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    for (int op = 0; op < N_OPS; op++) begin
      n      = rand_range(1, 4);
      sew    = sew_code_t'(rand_range(0, 3));
      down   = rand_range(0, 1) == 1;
      scalar = rand64();
      ebytes = 1 << sew;
      // Half the operations end on a full beat
      act    = (rand_range(0, 1) == 1) ? 8 / ebytes : rand_range(1, 8 / ebytes);
      avl    = byte_en_t'((1 << (act * ebytes)) - 1);
      name   = $sformatf("op%0d_%s_sew%0d", op, down ? "down" : "up", 8 << sew);
      for (int b = 0; b < n; b++) begin
        beats[b] = rand64();
      end
      // Tail bytes past the active part are zero
      for (int i = 0; i < 8; i++) begin
        if (!avl[i]) begin
          beats[n-1][i*8 +: 8] = 8'h00;
        end
      end
      for (int b = 0; b < n; b++) begin
        r        = '0;
        r.vec    = beats[b];
        r.scalar = scalar;
        r.sew    = sew;
        r.down   = down;
        r.start  = (b == 0);
        r.last   = (b == n - 1);
        r.addr   = vaddr_t'($random(seed));
        r.be     = byte_en_t'(rand_range(0, 255));
        r.avl_be = (b == n - 1) ? avl : byte_en_t'(rand_range(0, 255));
        r.off    = elem_off_t'(rand_range(0, 4095));
        e.vec    = ref_slide(beats, n, b, sew, down, scalar, avl);
        e.be     = r.be;
        e.addr   = r.addr;
        e.off    = down ? '0 : r.off;
        send_beat(r, e, $sformatf("%s_b%0d", name, b));
      end
      repeat (rand_range(0, 2)) send_idle();
    end

    repeat (2) send_idle();
    while (cyc_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    total = errors + dut.u_merge.u_asserts.fail_count;
    $display("beats checked %0d, errors %0d", checks, total);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare
    slide_resp_t e;
    string       name;
    int          due;
    if (out_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("out_valid high at cycle %0d with no beat outstanding", cycle);
        errors++;
      end
      if (exp_q.size() != 0) begin
        e    = exp_q.pop_front();
        name = name_q.pop_front();
        due  = cyc_q.pop_front();
        checks++;
        check_field(name, "cycle", 64'(due), 64'(cycle));
        check_field(name, "vec", e.vec, resp.vec);
        check_field(name, "be", 64'(e.be), 64'(resp.be));
        check_field(name, "addr", 64'(e.addr), 64'(resp.addr));
        check_field(name, "off", 64'(e.off), 64'(resp.off));
      end
    end else begin
      check_field("idle", "vec", 64'd0, resp.vec);
      if (cyc_q.size() != 0) begin
        assert (cyc_q[0] > cycle) else begin
          $display("beat %s never appeared, out_valid low at cycle %0d", name_q[0], cyc_q[0]);
          errors++;
          void'(exp_q.pop_front());
          void'(cyc_q.pop_front());
          void'(name_q.pop_front());
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle < MAX_CYCLES) begin
      @(posedge clk);
    end
    $display("timeout, run stopped after %0d cycles", cycle);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
